/* common/spw_rx_pkg.sv */
// SpaceWire receive buffer definitions
package spw_rx_pkg;

	// --------------------
	// Buffer sizing
	// --------------------

	localparam int FIFO_DEPTH  = 64;
	localparam int FIFO_AWIDTH = 6;

	// --------------------
	// Flow-control credit
	// --------------------

	// Characters granted by one FCT
	localparam int FCT_CHUNK    = 8;
	// Seven FCTs' worth after reset or flush
	localparam int CREDIT_INIT  = 56;
	localparam int CREDIT_WIDTH = 7;

	// --------------------
	// Character types
	// --------------------

	// Control code carried in the low two data bits of a control character
	typedef enum logic [1:0] {
		CODE_FCT = 2'b00,
		CODE_EOP = 2'b01,
		CODE_EEP = 2'b10,
		CODE_ESC = 2'b11
	} ctrl_code_t;

	// Normal character as held in the buffer
	typedef struct packed {
		logic       ctrl;
		logic [7:0] data;
	} nchar_t;

	// Decoded character from the link layer
	// esc_pair marks a null or a time code
	typedef struct packed {
		logic       esc_pair;
		logic       ctrl;
		logic [7:0] data;
	} link_char_t;

endpackage

/* dv/spw_rx_tb.sv */
// SpaceWire receive buffer testbench
`timescale 1ns/1ps

module spw_rx_tb;
	import spw_rx_pkg::*;

	// Longest test is about 400 cycles, so this leaves wide margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic                 clock;
	logic                 reset;
	link_char_t           link_char;
	logic                 link_strobe;
	logic                 link_running;
	logic                 rd_en;
	nchar_t               rd_data;
	logic                 rd_valid;
	logic                 empty;
	logic                 full;
	logic [FIFO_AWIDTH:0] count;
	logic                 fct_request;
	logic                 fct_received;
	logic                 credit_error;

	// Reference model state
	nchar_t model_q[$];
	int     model_credit;
	int     model_reads;
	logic   link_up;
	logic   expect_credit_error;

	int errors;
	int errors_before;
	int tests_run;
	int tests_failed;
	int cycles;

	spw_rx_top DUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic flag_error(input string msg);
		$display("error: time %0t: %s", $time, msg);
		errors++;
	endtask

	// --------------------
	// Concurrent checks
	// --------------------

	assert property (@(posedge clock) disable iff (!reset)
		(link_strobe && !link_char.esc_pair && link_char.ctrl &&
		link_char.data[1:0] == CODE_FCT) |=> fct_received)
		else flag_error("fct_received missing after an FCT strobe");

	assert property (@(posedge clock) disable iff (!reset)
		rd_valid |-> $past(rd_en && !empty))
		else flag_error("rd_valid without a read of a non-empty FIFO");

	assert property (@(posedge clock) disable iff (!reset)
		(rd_en && !empty && link_running) |=> rd_valid)
		else flag_error("read of a non-empty FIFO gave no rd_valid");

	// --------------------
	// Stimulus tasks
	// --------------------

	task automatic send_char(input logic esc, input logic ctrl, input logic [7:0] data);
		logic   stored;
		logic   is_fct;
		nchar_t entry;
		stored = !esc && (!ctrl || data[1:0] == CODE_EOP || data[1:0] == CODE_EEP);
		is_fct = !esc && ctrl && data[1:0] == CODE_FCT;
		entry.ctrl = ctrl;
		entry.data = data;
		@(negedge clock);
		link_char = '{esc_pair: esc, ctrl: ctrl, data: data};
		link_strobe = 1'b1;
		if (stored && link_up)
		begin
			if (model_credit == 0)
				expect_credit_error = 1'b1;
			else
			begin
				model_q.push_back(entry);
				model_credit--;
			end
		end
		@(negedge clock);
		link_strobe = 1'b0;
		assert (int'(count) == model_q.size())
			else flag_error($sformatf("count %0d, expected %0d", count, model_q.size()));
		assert (full == (model_q.size() == FIFO_DEPTH) && empty == (model_q.size() == 0))
			else flag_error($sformatf("full %0b empty %0b, expected %0b %0b", full, empty,
				model_q.size() == FIFO_DEPTH, model_q.size() == 0));
		assert (fct_received == is_fct) else flag_error("fct_received wrong after strobe");
		assert (credit_error == expect_credit_error)
			else flag_error($sformatf("credit_error %0b, expected %0b",
				credit_error, expect_credit_error));
	endtask

	task automatic read_char();
		nchar_t expected;
		logic   was_empty;
		logic   expect_fct;
		was_empty = (model_q.size() == 0);
		expect_fct = 1'b0;
		@(negedge clock);
		rd_en = 1'b1;
		@(negedge clock);
		rd_en = 1'b0;
		assert (rd_valid == !was_empty)
			else flag_error($sformatf("rd_valid %0b, expected %0b", rd_valid, !was_empty));
		if (!was_empty)
		begin
			expected = model_q.pop_front();
			assert (rd_data == expected)
				else flag_error($sformatf("rd_data %h, expected %h", rd_data, expected));
			model_reads++;
			// Every eighth read returns one chunk of credit
			if (model_reads % FCT_CHUNK == 0 && model_credit + FCT_CHUNK <= CREDIT_INIT)
			begin
				model_credit += FCT_CHUNK;
				expect_fct = 1'b1;
			end
		end
		assert (int'(count) == model_q.size())
			else flag_error($sformatf("count %0d, expected %0d", count, model_q.size()));
		@(negedge clock);
		assert (fct_request == expect_fct)
			else flag_error($sformatf("fct_request %0b, expected %0b", fct_request, expect_fct));
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b0;
		link_running = 1'b0;
		link_strobe = 1'b0;
		rd_en = 1'b0;
		link_up = 1'b0;
		repeat (2) @(negedge clock);
		reset = 1'b1;
		link_running = 1'b1;
		model_q.delete();
		model_credit = CREDIT_INIT;
		model_reads = 0;
		expect_credit_error = 1'b0;
		// Link FSM reaches running at the next edge
		@(negedge clock);
		link_up = 1'b1;
	endtask

	task automatic start_test();
		errors_before = errors;
		tests_run++;
		apply_reset();
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_before)
			$display("test %0d %s: passed", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial
	begin
		int filler;
		void'($urandom(32'h1aee));
		reset = 1'b0;
		link_char = '0;
		link_strobe = 1'b0;
		link_running = 1'b0;
		rd_en = 1'b0;
		link_up = 1'b0;
		expect_credit_error = 1'b0;
		model_credit = CREDIT_INIT;
		model_reads = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;

		// Data with markers, nulls and FCTs mixed in
		start_test();
		for (int i = 0; i < 40; i++)
		begin
			filler = $urandom % 4;
			if (filler == 0)
				send_char(1'b1, 1'b0, 8'($urandom));
			else if (filler == 1)
				send_char(1'b0, 1'b1, 8'h00);
			send_char(1'b0, 1'b0, 8'($urandom));
			if (i % 8 == 7)
				send_char(1'b0, 1'b1, ($urandom % 2) ? 8'h01 : 8'h02);
		end
		while (model_q.size() > 0)
			read_char();
		finish_test("ordered storage");

		start_test();
		assert (empty && count == '0 && !rd_valid && !fct_request && !fct_received &&
			!credit_error) else flag_error("outputs after reset are not idle");
		read_char();
		repeat (5) send_char(1'b0, 1'b0, 8'($urandom));
		repeat (6) read_char();
		finish_test("status flags");

		start_test();
		repeat (56) send_char(1'b0, 1'b0, 8'($urandom));
		send_char(1'b0, 1'b1, 8'h00);
		for (int g = 0; g < 7; g++)
		begin
			repeat (8) read_char();
			repeat (3) @(negedge clock);
		end
		finish_test("fct requests");

		start_test();
		repeat (57) send_char(1'b0, 1'b0, 8'($urandom));
		repeat (5)
		begin
			@(negedge clock);
			assert (credit_error) else flag_error("credit_error dropped before reset");
		end
		apply_reset();
		assert (!credit_error) else flag_error("credit_error still high after reset");
		finish_test("credit error");

		start_test();
		repeat (10) send_char(1'b0, 1'b0, 8'($urandom));
		@(negedge clock);
		link_running = 1'b0;
		link_up = 1'b0;
		model_q.delete();
		model_credit = CREDIT_INIT;
		model_reads = 0;
		@(negedge clock);
		assert (empty && count == '0) else flag_error("FIFO not emptied by link stop");
		repeat (3) send_char(1'b0, 1'b0, 8'($urandom));
		link_running = 1'b1;
		repeat (2) @(negedge clock);
		link_up = 1'b1;
		// Exactly a full credit fits before the error
		repeat (57) send_char(1'b0, 1'b0, 8'($urandom));
		finish_test("link flush");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the SpaceWire receive buffer testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module spw_rx_tb \
	--Mdir "$BUILD_DIR" -o spw_rx_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/spw_rx_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0

/* rx_fifo/rx_credit.sv */
// Receive flow-control credit
`timescale 1ns/1ps

module rx_credit (
	input  logic clock,
	input  logic reset,
	input  logic flush,
	input  logic wr_en,
	input  logic rd_done,
	output logic credit_ok,
	output logic fct_request,
	output logic credit_error
);
	import spw_rx_pkg::*;

	logic [CREDIT_WIDTH-1:0]                credit;
	logic [$clog2(FCT_CHUNK)-1:0]           chunk_cnt;
	logic [FIFO_AWIDTH-$clog2(FCT_CHUNK):0] pending;
	logic                                   wr_take;
	logic                                   chunk_done;
	logic                                   room;
	logic                                   grant;

	assign credit_ok = (credit != '0);
	assign wr_take = wr_en && credit_ok;

	// Eighth read of the current chunk
	assign chunk_done = rd_done && (chunk_cnt == ($clog2(FCT_CHUNK))'(FCT_CHUNK - 1));

	// Never grant beyond the reset credit
	assign room = (int'(credit) + FCT_CHUNK <= CREDIT_INIT);
	assign grant = (chunk_done || (pending != '0)) && room;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			credit <= CREDIT_WIDTH'(CREDIT_INIT);
			chunk_cnt <= '0;
			pending <= '0;
			fct_request <= 1'b0;
			credit_error <= 1'b0;
		end
		else
		begin
			// Sticky until reset, survives a flush
			if (wr_en && !credit_ok)
			begin
				credit_error <= 1'b1;
			end

			if (flush)
			begin
				credit <= CREDIT_WIDTH'(CREDIT_INIT);
				chunk_cnt <= '0;
				pending <= '0;
				fct_request <= 1'b0;
			end
			else
			begin
				fct_request <= grant;
				if (rd_done)
				begin
					chunk_cnt <= chunk_cnt + 1'b1;
				end

				// Chunks waiting for room
				if (chunk_done && !grant)
				begin
					pending <= pending + 1'b1;
				end
				else if (!chunk_done && grant)
				begin
					pending <= pending - 1'b1;
				end

				case ({grant, wr_take})
					2'b10:   credit <= credit + CREDIT_WIDTH'(FCT_CHUNK);
					2'b11:   credit <= credit + CREDIT_WIDTH'(FCT_CHUNK - 1);
					2'b01:   credit <= credit - 1'b1;
					default: credit <= credit;
				endcase
			end
		end
	end

endmodule

/* rx_fifo/rx_fifo.sv */
// Receive character FIFO
`timescale 1ns/1ps

module rx_fifo (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             flush,
	input  logic                             wr_en,
	input  spw_rx_pkg::nchar_t               wr_char,
	input  logic                             credit_ok,
	input  logic                             rd_en,
	output spw_rx_pkg::nchar_t               rd_data,
	output logic                             rd_valid,
	output logic                             rd_done,
	output logic                             empty,
	output logic                             full,
	output logic [spw_rx_pkg::FIFO_AWIDTH:0] count
);
	import spw_rx_pkg::*;

	nchar_t                 mem [FIFO_DEPTH];
	logic [FIFO_AWIDTH-1:0] wr_ptr;
	logic [FIFO_AWIDTH-1:0] rd_ptr;
	logic                   wr_take;
	logic                   rd_take;

	// --------------------
	// Status and accept
	// --------------------

	assign empty = (count == '0);
	assign full = (count == (FIFO_AWIDTH + 1)'(FIFO_DEPTH));

	// Flush wins over both ports
	assign wr_take = wr_en && credit_ok && !full && !flush;
	assign rd_take = rd_en && !empty && !flush;

	// Completed read, in step with the returned character
	assign rd_done = rd_valid;

	// --------------------
	// Storage
	// --------------------

	always_ff @(posedge clock)
	begin
		if (wr_take)
		begin
			mem[wr_ptr] <= wr_char;
		end
	end

	// Head character registered on a read
	always_ff @(posedge clock)
	begin
		if (rd_take)
		begin
			rd_data <= mem[rd_ptr];
		end
	end

	// --------------------
	// Pointers and count
	// --------------------

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_valid <= 1'b0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_take;
			if (wr_take)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_take)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous read and write leaves the count alone
			case ({wr_take, rd_take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* source/rx_control.sv */
// Receive character control
`timescale 1ns/1ps

module rx_control (
	input  logic                   clock,
	input  logic                   reset,
	input  spw_rx_pkg::link_char_t link_char,
	input  logic                   link_strobe,
	input  logic                   link_running,
	output logic                   wr_en,
	output spw_rx_pkg::nchar_t     wr_char,
	output logic                   flush,
	output logic                   fct_received
);
	import spw_rx_pkg::*;

	typedef enum logic [1:0] {
		S_STOPPED,
		S_RUNNING,
		S_FLUSHING
	} link_state_t;

	link_state_t state;
	link_state_t state_next;
	ctrl_code_t  code;
	logic        is_stored;
	logic        is_fct;

	// --------------------
	// Character decode
	// --------------------

	assign code = ctrl_code_t'(link_char.data[1:0]);

	always_comb
	begin
		is_stored = 1'b0;
		is_fct = 1'b0;
		// Nulls and time codes never reach the buffer
		if (!link_char.esc_pair)
		begin
			if (!link_char.ctrl)
			begin
				is_stored = 1'b1;
			end
			else
			begin
				case (code)
					CODE_FCT: is_fct = 1'b1;
					CODE_EOP: is_stored = 1'b1;
					CODE_EEP: is_stored = 1'b1;
					// Lone escape is dropped
					default: is_stored = 1'b0;
				endcase
			end
		end
	end

	// Writes only while the link is up and not being torn down
	assign wr_en = link_strobe && is_stored && (state == S_RUNNING) && link_running;
	assign wr_char = '{ctrl: link_char.ctrl, data: link_char.data};

	// One-cycle flush on the first cycle the link is seen down
	assign flush = (state == S_RUNNING) && !link_running;

	// --------------------
	// Link state FSM
	// --------------------

	always_comb
	begin
		state_next = state;
		case (state)
			S_STOPPED:  if (link_running) state_next = S_RUNNING;
			S_RUNNING:  if (!link_running) state_next = S_FLUSHING;
			// Settle one cycle before the link may restart
			S_FLUSHING: state_next = S_STOPPED;
			default:    state_next = S_STOPPED;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= S_STOPPED;
			fct_received <= 1'b0;
		end
		else
		begin
			state <= state_next;
			fct_received <= link_strobe && is_fct;
		end
	end

endmodule

/* source/spw_rx_top.sv */
// SpaceWire receive buffer top level
`timescale 1ns/1ps

module spw_rx_top (
	input  logic                            clock,
	input  logic                            reset,
	// Link side
	input  spw_rx_pkg::link_char_t          link_char,
	input  logic                            link_strobe,
	input  logic                            link_running,
	// Host side
	input  logic                            rd_en,
	output spw_rx_pkg::nchar_t              rd_data,
	output logic                            rd_valid,
	// Status
	output logic                            empty,
	output logic                            full,
	output logic [spw_rx_pkg::FIFO_AWIDTH:0] count,
	// Flow control
	output logic                            fct_request,
	output logic                            fct_received,
	output logic                            credit_error
);
	import spw_rx_pkg::*;

	logic   wr_en;
	nchar_t wr_char;
	logic   flush;
	logic   credit_ok;
	logic   rd_done;

	rx_control u_rx_control (
		.clock        (clock),
		.reset        (reset),
		.link_char    (link_char),
		.link_strobe  (link_strobe),
		.link_running (link_running),
		.wr_en        (wr_en),
		.wr_char      (wr_char),
		.flush        (flush),
		.fct_received (fct_received)
	);

	rx_fifo u_rx_fifo (
		.clock     (clock),
		.reset     (reset),
		.flush     (flush),
		.wr_en     (wr_en),
		.wr_char   (wr_char),
		.credit_ok (credit_ok),
		.rd_en     (rd_en),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.rd_done   (rd_done),
		.empty     (empty),
		.full      (full),
		.count     (count)
	);

	rx_credit u_rx_credit (
		.clock        (clock),
		.reset        (reset),
		.flush        (flush),
		.wr_en        (wr_en),
		.rd_done      (rd_done),
		.credit_ok    (credit_ok),
		.fct_request  (fct_request),
		.credit_error (credit_error)
	);

endmodule

/* src.f */
common/spw_rx_pkg.sv
source/rx_control.sv
rx_fifo/rx_fifo.sv
rx_fifo/rx_credit.sv
source/spw_rx_top.sv
dv/spw_rx_tb.sv
